// ==== verilog/soc_pkg.sv ====
package soc_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int RESP_W = 2;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [RESP_W-1:0] resp_t;

	// read response payload
	typedef struct packed {
		data_t data;
		resp_t resp;
	} r_chan_t;

	// write data payload
	typedef struct packed {
		data_t data;
		strb_t strb;
	} w_chan_t;

	typedef enum logic [1:0] {
		SEL_SRAM,
		SEL_UART,
		SEL_CLINT,
		SEL_NONE
	} slave_sel_t;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_DECERR = 2'd3;

	// address map
	localparam addr_t SRAM_BASE  = 32'h8000_0000;
	localparam int    SRAM_WORDS = 1024;
	localparam int    SRAM_IDX_W = $clog2(SRAM_WORDS);
	localparam addr_t SRAM_BYTES = addr_t'(SRAM_WORDS * STRB_W);
	localparam addr_t UART_ADDR  = 32'ha000_03f8;
	localparam addr_t CLINT_BASE  = 32'ha000_0048;
	localparam addr_t CLINT_BYTES = 32'd8;

endpackage

// ==== verilog/axi_arbiter.sv ====
`timescale 1ns/100ps

module axi_arbiter (
	input  logic             clock,
	input  logic             rst_i,
	input  soc_pkg::addr_t   inst_ar_addr_i,
	input  logic             inst_ar_valid_i,
	output logic             inst_ar_ready_o,
	output soc_pkg::r_chan_t inst_r_o,
	output logic             inst_r_valid_o,
	input  logic             inst_r_ready_i,
	input  soc_pkg::addr_t   data_ar_addr_i,
	input  logic             data_ar_valid_i,
	output logic             data_ar_ready_o,
	output soc_pkg::r_chan_t data_r_o,
	output logic             data_r_valid_o,
	input  logic             data_r_ready_i,
	input  soc_pkg::addr_t   data_aw_addr_i,
	input  logic             data_aw_valid_i,
	output logic             data_aw_ready_o,
	input  soc_pkg::w_chan_t data_w_i,
	input  logic             data_w_valid_i,
	output logic             data_w_ready_o,
	output soc_pkg::resp_t   data_b_resp_o,
	output logic             data_b_valid_o,
	input  logic             data_b_ready_i,
	output soc_pkg::addr_t   bus_ar_addr_o,
	output logic             bus_ar_valid_o,
	input  logic             bus_ar_ready_i,
	input  soc_pkg::r_chan_t bus_r_i,
	input  logic             bus_r_valid_i,
	output logic             bus_r_ready_o,
	output soc_pkg::addr_t   bus_aw_addr_o,
	output logic             bus_aw_valid_o,
	input  logic             bus_aw_ready_i,
	output soc_pkg::w_chan_t bus_w_o,
	output logic             bus_w_valid_o,
	input  logic             bus_w_ready_i,
	input  soc_pkg::resp_t   bus_b_resp_i,
	input  logic             bus_b_valid_i,
	output logic             bus_b_ready_o
);
	import soc_pkg::*;

	typedef enum logic [1:0] {IDLE, FETCH, LOAD, STORE} arb_state_t;

	arb_state_t state_q;
	addr_t      addr_q;
	w_chan_t    w_q;
	logic       ar_pend_q;
	logic       aw_pend_q;
	logic       w_pend_q;
	logic       idle;
	logic       grant_wr;
	logic       grant_rd;
	logic       grant_if;

	// store before load before fetch
	assign idle     = (state_q == IDLE);
	assign grant_wr = idle & data_aw_valid_i & data_w_valid_i;
	assign grant_rd = idle & data_ar_valid_i & ~grant_wr;
	assign grant_if = idle & inst_ar_valid_i & ~grant_wr & ~data_ar_valid_i;

	assign data_aw_ready_o = grant_wr;
	assign data_w_ready_o  = grant_wr;
	assign data_ar_ready_o = grant_rd;
	assign inst_ar_ready_o = grant_if;

	// granted request replayed from registers
	assign bus_ar_addr_o  = addr_q;
	assign bus_ar_valid_o = ar_pend_q;
	assign bus_aw_addr_o  = addr_q;
	assign bus_aw_valid_o = aw_pend_q;
	assign bus_w_o        = w_q;
	assign bus_w_valid_o  = w_pend_q;

	// responses only reach the owner
	assign inst_r_o       = bus_r_i;
	assign data_r_o       = bus_r_i;
	assign inst_r_valid_o = (state_q == FETCH) & bus_r_valid_i;
	assign data_r_valid_o = (state_q == LOAD) & bus_r_valid_i;
	assign bus_r_ready_o  = ((state_q == FETCH) & inst_r_ready_i) |
		((state_q == LOAD) & data_r_ready_i);
	assign data_b_resp_o  = bus_b_resp_i;
	assign data_b_valid_o = (state_q == STORE) & bus_b_valid_i;
	assign bus_b_ready_o  = (state_q == STORE) & data_b_ready_i;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			state_q   <= IDLE;
			ar_pend_q <= 1'b0;
			aw_pend_q <= 1'b0;
			w_pend_q  <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (grant_wr) begin
						state_q   <= STORE;
						aw_pend_q <= 1'b1;
						w_pend_q  <= 1'b1;
					end else if (grant_rd) begin
						state_q   <= LOAD;
						ar_pend_q <= 1'b1;
					end else if (grant_if) begin
						state_q   <= FETCH;
						ar_pend_q <= 1'b1;
					end
				end
				FETCH, LOAD: begin
					if (ar_pend_q && bus_ar_ready_i)
						ar_pend_q <= 1'b0;
					if (bus_r_valid_i && bus_r_ready_o)
						state_q <= IDLE;
				end
				STORE: begin
					if (aw_pend_q && bus_aw_ready_i)
						aw_pend_q <= 1'b0;
					if (w_pend_q && bus_w_ready_i)
						w_pend_q <= 1'b0;
					if (bus_b_valid_i && bus_b_ready_o)
						state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (grant_wr) begin
			addr_q <= data_aw_addr_i;
			w_q    <= data_w_i;
		end else if (grant_rd) begin
			addr_q <= data_ar_addr_i;
		end else if (grant_if) begin
			addr_q <= inst_ar_addr_i;
		end
	end

endmodule

// ==== verilog/axi_xbar.sv ====
`timescale 1ns/100ps

module axi_xbar (
	input  logic             clock,
	input  logic             rst_i,
	input  soc_pkg::addr_t   bus_ar_addr_i,
	input  logic             bus_ar_valid_i,
	output logic             bus_ar_ready_o,
	output soc_pkg::r_chan_t bus_r_o,
	output logic             bus_r_valid_o,
	input  logic             bus_r_ready_i,
	input  soc_pkg::addr_t   bus_aw_addr_i,
	input  logic             bus_aw_valid_i,
	output logic             bus_aw_ready_o,
	input  soc_pkg::w_chan_t bus_w_i,
	input  logic             bus_w_valid_i,
	output logic             bus_w_ready_o,
	output soc_pkg::resp_t   bus_b_resp_o,
	output logic             bus_b_valid_o,
	input  logic             bus_b_ready_i,
	output soc_pkg::addr_t   sram_ar_addr_o,
	output logic             sram_ar_valid_o,
	input  logic             sram_ar_ready_i,
	input  soc_pkg::r_chan_t sram_r_i,
	input  logic             sram_r_valid_i,
	output logic             sram_r_ready_o,
	output soc_pkg::addr_t   sram_aw_addr_o,
	output logic             sram_aw_valid_o,
	input  logic             sram_aw_ready_i,
	output soc_pkg::w_chan_t sram_w_o,
	output logic             sram_w_valid_o,
	input  logic             sram_w_ready_i,
	input  soc_pkg::resp_t   sram_b_resp_i,
	input  logic             sram_b_valid_i,
	output logic             sram_b_ready_o,
	output logic             uart_aw_valid_o,
	input  logic             uart_aw_ready_i,
	output soc_pkg::w_chan_t uart_w_o,
	output logic             uart_w_valid_o,
	input  logic             uart_w_ready_i,
	input  soc_pkg::resp_t   uart_b_resp_i,
	input  logic             uart_b_valid_i,
	output logic             uart_b_ready_o,
	output soc_pkg::addr_t   clint_ar_addr_o,
	output logic             clint_ar_valid_o,
	input  logic             clint_ar_ready_i,
	input  soc_pkg::r_chan_t clint_r_i,
	input  logic             clint_r_valid_i,
	output logic             clint_r_ready_o
);
	import soc_pkg::*;

	slave_sel_t rd_sel;
	slave_sel_t wr_sel;
	slave_sel_t rd_sel_q;
	slave_sel_t wr_sel_q;
	logic       err_r_valid_q;
	logic       err_b_valid_q;

	function automatic slave_sel_t decode(input addr_t addr);
		if ((addr - SRAM_BASE) < SRAM_BYTES)
			return SEL_SRAM;
		if (addr[ADDR_W-1:2] == UART_ADDR[ADDR_W-1:2])
			return SEL_UART;
		if ((addr - CLINT_BASE) < CLINT_BYTES)
			return SEL_CLINT;
		return SEL_NONE;
	endfunction

	// uart reads and clint writes fall to the error responder
	always_comb begin
		rd_sel = decode(bus_ar_addr_i);
		if (rd_sel == SEL_UART)
			rd_sel = SEL_NONE;
		// w may trail aw, so keep the stored selection once aw is gone
		wr_sel = bus_aw_valid_i ? decode(bus_aw_addr_i) : wr_sel_q;
		if (wr_sel == SEL_CLINT)
			wr_sel = SEL_NONE;
	end

	assign sram_ar_addr_o   = bus_ar_addr_i;
	assign clint_ar_addr_o  = bus_ar_addr_i;
	assign sram_ar_valid_o  = bus_ar_valid_i & (rd_sel == SEL_SRAM);
	assign clint_ar_valid_o = bus_ar_valid_i & (rd_sel == SEL_CLINT);

	assign sram_aw_addr_o  = bus_aw_addr_i;
	assign sram_w_o        = bus_w_i;
	assign uart_w_o        = bus_w_i;
	assign sram_aw_valid_o = bus_aw_valid_i & (wr_sel == SEL_SRAM);
	assign uart_aw_valid_o = bus_aw_valid_i & (wr_sel == SEL_UART);
	assign sram_w_valid_o  = bus_w_valid_i & (wr_sel == SEL_SRAM);
	assign uart_w_valid_o  = bus_w_valid_i & (wr_sel == SEL_UART);

	assign sram_r_ready_o  = bus_r_ready_i & (rd_sel_q == SEL_SRAM);
	assign clint_r_ready_o = bus_r_ready_i & (rd_sel_q == SEL_CLINT);
	assign sram_b_ready_o  = bus_b_ready_i & (wr_sel_q == SEL_SRAM);
	assign uart_b_ready_o  = bus_b_ready_i & (wr_sel_q == SEL_UART);

	always_comb begin
		case (rd_sel)
			SEL_SRAM:  bus_ar_ready_o = sram_ar_ready_i;
			SEL_CLINT: bus_ar_ready_o = clint_ar_ready_i;
			default:   bus_ar_ready_o = ~err_r_valid_q;
		endcase
		// error responder takes aw and w together
		case (wr_sel)
			SEL_SRAM: begin
				bus_aw_ready_o = sram_aw_ready_i;
				bus_w_ready_o  = sram_w_ready_i;
			end
			SEL_UART: begin
				bus_aw_ready_o = uart_aw_ready_i;
				bus_w_ready_o  = uart_w_ready_i;
			end
			default: begin
				bus_aw_ready_o = ~err_b_valid_q & bus_w_valid_i;
				bus_w_ready_o  = ~err_b_valid_q & bus_aw_valid_i;
			end
		endcase
	end

	// response steering by the stored selection
	always_comb begin
		case (rd_sel_q)
			SEL_SRAM: begin
				bus_r_o       = sram_r_i;
				bus_r_valid_o = sram_r_valid_i;
			end
			SEL_CLINT: begin
				bus_r_o       = clint_r_i;
				bus_r_valid_o = clint_r_valid_i;
			end
			default: begin
				bus_r_o       = '{data: '0, resp: RESP_DECERR};
				bus_r_valid_o = err_r_valid_q;
			end
		endcase
		case (wr_sel_q)
			SEL_SRAM: begin
				bus_b_resp_o  = sram_b_resp_i;
				bus_b_valid_o = sram_b_valid_i;
			end
			SEL_UART: begin
				bus_b_resp_o  = uart_b_resp_i;
				bus_b_valid_o = uart_b_valid_i;
			end
			default: begin
				bus_b_resp_o  = RESP_DECERR;
				bus_b_valid_o = err_b_valid_q;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst_i) begin
			rd_sel_q      <= SEL_NONE;
			wr_sel_q      <= SEL_NONE;
			err_r_valid_q <= 1'b0;
			err_b_valid_q <= 1'b0;
		end else begin
			if (bus_ar_valid_i && bus_ar_ready_o) begin
				rd_sel_q      <= rd_sel;
				err_r_valid_q <= (rd_sel == SEL_NONE);
			end else if (err_r_valid_q && bus_r_ready_i) begin
				err_r_valid_q <= 1'b0;
			end
			if (bus_aw_valid_i && bus_aw_ready_o) begin
				wr_sel_q      <= wr_sel;
				err_b_valid_q <= (wr_sel == SEL_NONE);
			end else if (err_b_valid_q && bus_b_ready_i) begin
				err_b_valid_q <= 1'b0;
			end
		end
	end

endmodule

// ==== verilog/axi_sram.sv ====
`timescale 1ns/100ps

module axi_sram (
	input  logic             clock,
	input  logic             rst_i,
	input  soc_pkg::addr_t   ar_addr_i,
	input  logic             ar_valid_i,
	output logic             ar_ready_o,
	output soc_pkg::r_chan_t r_o,
	output logic             r_valid_o,
	input  logic             r_ready_i,
	input  soc_pkg::addr_t   aw_addr_i,
	input  logic             aw_valid_i,
	output logic             aw_ready_o,
	input  soc_pkg::w_chan_t w_i,
	input  logic             w_valid_i,
	output logic             w_ready_o,
	output soc_pkg::resp_t   b_resp_o,
	output logic             b_valid_o,
	input  logic             b_ready_i
);
	import soc_pkg::*;

	data_t                 mem [SRAM_WORDS];
	data_t                 rdata_q;
	logic                  r_valid_q;
	logic                  b_valid_q;
	logic                  rd_take;
	logic                  wr_take;
	logic [SRAM_IDX_W-1:0] ridx;
	logic [SRAM_IDX_W-1:0] widx;

	// word index from address bits 11:2
	assign ridx = ar_addr_i[SRAM_IDX_W+1:2];
	assign widx = aw_addr_i[SRAM_IDX_W+1:2];

	assign ar_ready_o = ~r_valid_q;
	assign aw_ready_o = ~b_valid_q & w_valid_i;
	assign w_ready_o  = ~b_valid_q & aw_valid_i;
	assign rd_take    = ar_valid_i & ar_ready_o;
	assign wr_take    = aw_valid_i & w_valid_i & ~b_valid_q;

	assign r_o       = '{data: rdata_q, resp: RESP_OKAY};
	assign r_valid_o = r_valid_q;
	assign b_resp_o  = RESP_OKAY;
	assign b_valid_o = b_valid_q;

	always_ff @(posedge clock) begin
		if (wr_take) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (w_i.strb[i])
					mem[widx][8*i +: 8] <= w_i.data[8*i +: 8];
			end
		end
		if (rd_take)
			rdata_q <= mem[ridx];
	end

	// responses held until taken
	always_ff @(posedge clock) begin
		if (rst_i) begin
			r_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			if (rd_take)
				r_valid_q <= 1'b1;
			else if (r_valid_q && r_ready_i)
				r_valid_q <= 1'b0;
			if (wr_take)
				b_valid_q <= 1'b1;
			else if (b_valid_q && b_ready_i)
				b_valid_q <= 1'b0;
		end
	end

endmodule

// ==== verilog/axi_uart.sv ====
`timescale 1ns/100ps

module axi_uart (
	input  logic             clock,
	input  logic             rst_i,
	input  logic             aw_valid_i,
	output logic             aw_ready_o,
	input  soc_pkg::w_chan_t w_i,
	input  logic             w_valid_i,
	output logic             w_ready_o,
	output soc_pkg::resp_t   b_resp_o,
	output logic             b_valid_o,
	input  logic             b_ready_i,
	output logic [7:0]       tx_o,
	output logic             tx_valid_o
);
	import soc_pkg::*;

	logic b_valid_q;
	logic wr_take;

	// address and data accepted in the same cycle
	assign aw_ready_o = ~b_valid_q & w_valid_i;
	assign w_ready_o  = ~b_valid_q & aw_valid_i;
	assign wr_take    = aw_valid_i & w_valid_i & ~b_valid_q;
	assign b_resp_o   = RESP_OKAY;
	assign b_valid_o  = b_valid_q;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			b_valid_q  <= 1'b0;
			tx_valid_o <= 1'b0;
		end else begin
			// strobe lines up with the first cycle of b valid
			tx_valid_o <= wr_take;
			if (wr_take)
				b_valid_q <= 1'b1;
			else if (b_valid_q && b_ready_i)
				b_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_take)
			tx_o <= w_i.data[7:0];
	end

endmodule

// ==== verilog/axi_clint.sv ====
`timescale 1ns/100ps

module axi_clint (
	input  logic             clock,
	input  logic             rst_i,
	input  soc_pkg::addr_t   ar_addr_i,
	input  logic             ar_valid_i,
	output logic             ar_ready_o,
	output soc_pkg::r_chan_t r_o,
	output logic             r_valid_o,
	input  logic             r_ready_i
);
	import soc_pkg::*;

	logic [2*DATA_W-1:0] mtime_q;
	data_t               hi_q;
	data_t               rdata_q;
	logic                r_valid_q;
	logic                rd_take;

	assign ar_ready_o = ~r_valid_q;
	assign rd_take    = ar_valid_i & ar_ready_o;
	assign r_o        = '{data: rdata_q, resp: RESP_OKAY};
	assign r_valid_o  = r_valid_q;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			mtime_q   <= '0;
			hi_q      <= '0;
			r_valid_q <= 1'b0;
		end else begin
			mtime_q <= mtime_q + 1'b1;
			if (rd_take) begin
				r_valid_q <= 1'b1;
				// snapshot upper half on a low word read
				if (!ar_addr_i[2])
					hi_q <= mtime_q[2*DATA_W-1:DATA_W];
			end else if (r_valid_q && r_ready_i) begin
				r_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rd_take)
			rdata_q <= ar_addr_i[2] ? hi_q : mtime_q[DATA_W-1:0];
	end

endmodule

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/100ps

module mem_subsys_top (
	input  logic             clock,
	input  logic             rst_i,
	input  soc_pkg::addr_t   inst_ar_addr_i,
	input  logic             inst_ar_valid_i,
	output logic             inst_ar_ready_o,
	output soc_pkg::r_chan_t inst_r_o,
	output logic             inst_r_valid_o,
	input  logic             inst_r_ready_i,
	input  soc_pkg::addr_t   data_ar_addr_i,
	input  logic             data_ar_valid_i,
	output logic             data_ar_ready_o,
	output soc_pkg::r_chan_t data_r_o,
	output logic             data_r_valid_o,
	input  logic             data_r_ready_i,
	input  soc_pkg::addr_t   data_aw_addr_i,
	input  logic             data_aw_valid_i,
	output logic             data_aw_ready_o,
	input  soc_pkg::w_chan_t data_w_i,
	input  logic             data_w_valid_i,
	output logic             data_w_ready_o,
	output soc_pkg::resp_t   data_b_resp_o,
	output logic             data_b_valid_o,
	input  logic             data_b_ready_i,
	output logic [7:0]       uart_tx_o,
	output logic             uart_tx_valid_o
);
	import soc_pkg::*;

	// shared bus between arbiter and crossbar
	addr_t   bus_ar_addr;
	addr_t   bus_aw_addr;
	r_chan_t bus_r;
	w_chan_t bus_w;
	resp_t   bus_b_resp;
	logic    bus_ar_valid, bus_ar_ready, bus_r_valid, bus_r_ready;
	logic    bus_aw_valid, bus_aw_ready, bus_w_valid, bus_w_ready;
	logic    bus_b_valid, bus_b_ready;

	addr_t   sram_ar_addr;
	addr_t   sram_aw_addr;
	r_chan_t sram_r;
	w_chan_t sram_w;
	resp_t   sram_b_resp;
	logic    sram_ar_valid, sram_ar_ready, sram_r_valid, sram_r_ready;
	logic    sram_aw_valid, sram_aw_ready, sram_w_valid, sram_w_ready;
	logic    sram_b_valid, sram_b_ready;

	w_chan_t uart_w;
	resp_t   uart_b_resp;
	logic    uart_aw_valid, uart_aw_ready, uart_w_valid, uart_w_ready;
	logic    uart_b_valid, uart_b_ready;

	addr_t   clint_ar_addr;
	r_chan_t clint_r;
	logic    clint_ar_valid, clint_ar_ready, clint_r_valid, clint_r_ready;

	// master ports share their names with the top level
	axi_arbiter u_arbiter (
		.*,
		.bus_ar_addr_o  (bus_ar_addr),
		.bus_ar_valid_o (bus_ar_valid),
		.bus_ar_ready_i (bus_ar_ready),
		.bus_r_i        (bus_r),
		.bus_r_valid_i  (bus_r_valid),
		.bus_r_ready_o  (bus_r_ready),
		.bus_aw_addr_o  (bus_aw_addr),
		.bus_aw_valid_o (bus_aw_valid),
		.bus_aw_ready_i (bus_aw_ready),
		.bus_w_o        (bus_w),
		.bus_w_valid_o  (bus_w_valid),
		.bus_w_ready_i  (bus_w_ready),
		.bus_b_resp_i   (bus_b_resp),
		.bus_b_valid_i  (bus_b_valid),
		.bus_b_ready_o  (bus_b_ready)
	);

	axi_xbar u_xbar (
		.clock            (clock),
		.rst_i            (rst_i),
		.bus_ar_addr_i    (bus_ar_addr),
		.bus_ar_valid_i   (bus_ar_valid),
		.bus_ar_ready_o   (bus_ar_ready),
		.bus_r_o          (bus_r),
		.bus_r_valid_o    (bus_r_valid),
		.bus_r_ready_i    (bus_r_ready),
		.bus_aw_addr_i    (bus_aw_addr),
		.bus_aw_valid_i   (bus_aw_valid),
		.bus_aw_ready_o   (bus_aw_ready),
		.bus_w_i          (bus_w),
		.bus_w_valid_i    (bus_w_valid),
		.bus_w_ready_o    (bus_w_ready),
		.bus_b_resp_o     (bus_b_resp),
		.bus_b_valid_o    (bus_b_valid),
		.bus_b_ready_i    (bus_b_ready),
		.sram_ar_addr_o   (sram_ar_addr),
		.sram_ar_valid_o  (sram_ar_valid),
		.sram_ar_ready_i  (sram_ar_ready),
		.sram_r_i         (sram_r),
		.sram_r_valid_i   (sram_r_valid),
		.sram_r_ready_o   (sram_r_ready),
		.sram_aw_addr_o   (sram_aw_addr),
		.sram_aw_valid_o  (sram_aw_valid),
		.sram_aw_ready_i  (sram_aw_ready),
		.sram_w_o         (sram_w),
		.sram_w_valid_o   (sram_w_valid),
		.sram_w_ready_i   (sram_w_ready),
		.sram_b_resp_i    (sram_b_resp),
		.sram_b_valid_i   (sram_b_valid),
		.sram_b_ready_o   (sram_b_ready),
		.uart_aw_valid_o  (uart_aw_valid),
		.uart_aw_ready_i  (uart_aw_ready),
		.uart_w_o         (uart_w),
		.uart_w_valid_o   (uart_w_valid),
		.uart_w_ready_i   (uart_w_ready),
		.uart_b_resp_i    (uart_b_resp),
		.uart_b_valid_i   (uart_b_valid),
		.uart_b_ready_o   (uart_b_ready),
		.clint_ar_addr_o  (clint_ar_addr),
		.clint_ar_valid_o (clint_ar_valid),
		.clint_ar_ready_i (clint_ar_ready),
		.clint_r_i        (clint_r),
		.clint_r_valid_i  (clint_r_valid),
		.clint_r_ready_o  (clint_r_ready)
	);

	axi_sram u_sram (
		.clock      (clock),
		.rst_i      (rst_i),
		.ar_addr_i  (sram_ar_addr),
		.ar_valid_i (sram_ar_valid),
		.ar_ready_o (sram_ar_ready),
		.r_o        (sram_r),
		.r_valid_o  (sram_r_valid),
		.r_ready_i  (sram_r_ready),
		.aw_addr_i  (sram_aw_addr),
		.aw_valid_i (sram_aw_valid),
		.aw_ready_o (sram_aw_ready),
		.w_i        (sram_w),
		.w_valid_i  (sram_w_valid),
		.w_ready_o  (sram_w_ready),
		.b_resp_o   (sram_b_resp),
		.b_valid_o  (sram_b_valid),
		.b_ready_i  (sram_b_ready)
	);

	axi_uart u_uart (
		.clock      (clock),
		.rst_i      (rst_i),
		.aw_valid_i (uart_aw_valid),
		.aw_ready_o (uart_aw_ready),
		.w_i        (uart_w),
		.w_valid_i  (uart_w_valid),
		.w_ready_o  (uart_w_ready),
		.b_resp_o   (uart_b_resp),
		.b_valid_o  (uart_b_valid),
		.b_ready_i  (uart_b_ready),
		.tx_o       (uart_tx_o),
		.tx_valid_o (uart_tx_valid_o)
	);

	axi_clint u_clint (
		.clock      (clock),
		.rst_i      (rst_i),
		.ar_addr_i  (clint_ar_addr),
		.ar_valid_i (clint_ar_valid),
		.ar_ready_o (clint_ar_ready),
		.r_o        (clint_r),
		.r_valid_o  (clint_r_valid),
		.r_ready_i  (clint_r_ready)
	);

endmodule

// ==== testbench/tb_mem_subsys.sv ====
`timescale 1ns/100ps

module tb_mem_subsys;
	import soc_pkg::*;

	localparam int    NWORDS   = 16;
	localparam int    TIMEOUT  = 100;
	localparam addr_t UNMAPPED = 32'h4000_0000;

	logic       clock;
	logic       rst_i;
	addr_t      inst_ar_addr_i;
	logic       inst_ar_valid_i;
	logic       inst_ar_ready_o;
	r_chan_t    inst_r_o;
	logic       inst_r_valid_o;
	logic       inst_r_ready_i;
	addr_t      data_ar_addr_i;
	logic       data_ar_valid_i;
	logic       data_ar_ready_o;
	r_chan_t    data_r_o;
	logic       data_r_valid_o;
	logic       data_r_ready_i;
	addr_t      data_aw_addr_i;
	logic       data_aw_valid_i;
	logic       data_aw_ready_o;
	w_chan_t    data_w_i;
	logic       data_w_valid_i;
	logic       data_w_ready_o;
	resp_t      data_b_resp_o;
	logic       data_b_valid_o;
	logic       data_b_ready_i;
	logic [7:0] uart_tx_o;
	logic       uart_tx_valid_o;

	int          errors;
	int          checks;
	bit          inst_busy;
	bit          load_busy;
	bit          store_busy;
	data_t       model [SRAM_WORDS];
	int unsigned idx_list [NWORDS];

	mem_subsys_top DUT (.*);

	always #5 clock = ~clock;

	// payloads hold while a response is stalled
	inst_r_hold: assert property (@(posedge clock) disable iff (rst_i)
		inst_r_valid_o && !inst_r_ready_i |=> inst_r_valid_o && $stable(inst_r_o))
		else begin
			errors++;
			$display("fetch response dropped or changed while stalled");
		end

	data_r_hold: assert property (@(posedge clock) disable iff (rst_i)
		data_r_valid_o && !data_r_ready_i |=> data_r_valid_o && $stable(data_r_o))
		else begin
			errors++;
			$display("data read response dropped or changed while stalled");
		end

	data_b_hold: assert property (@(posedge clock) disable iff (rst_i)
		data_b_valid_o && !data_b_ready_i |=> data_b_valid_o && $stable(data_b_resp_o))
		else begin
			errors++;
			$display("write response dropped or changed while stalled");
		end

	uart_strobe: assert property (@(posedge clock) disable iff (rst_i)
		uart_tx_valid_o |=> !uart_tx_valid_o)
		else begin
			errors++;
			$display("uart strobe lasted more than one cycle");
		end

	// a response only shows up on a port that asked for one
	inst_owner: assert property (@(posedge clock) disable iff (rst_i)
		inst_r_valid_o |-> inst_busy)
		else begin
			errors++;
			$display("fetch port got a response it never requested");
		end

	load_owner: assert property (@(posedge clock) disable iff (rst_i)
		data_r_valid_o |-> load_busy)
		else begin
			errors++;
			$display("data read port got a response it never requested");
		end

	store_owner: assert property (@(posedge clock) disable iff (rst_i)
		data_b_valid_o |-> store_busy)
		else begin
			errors++;
			$display("write response port got a response it never requested");
		end

	function automatic data_t merge_strobes(data_t old_word, data_t new_word, strb_t strb);
		data_t res;
		res = old_word;
		for (int b = 0; b < STRB_W; b++) begin
			if (strb[b])
				res[8*b +: 8] = new_word[8*b +: 8];
		end
		return res;
	endfunction

	function automatic addr_t word_addr(int k);
		return SRAM_BASE + addr_t'(idx_list[k] << 2);
	endfunction

	task automatic expect_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("timeout while waiting for %s", what);
	endtask

	// enters and leaves 1 ns after a rising edge
	task automatic read_port(input bit fetch, input addr_t addr, output r_chan_t rsp);
		int n;
		bit done;
		bit rdy;
		rsp = '0;
		if (fetch) begin
			inst_ar_addr_i  = addr;
			inst_ar_valid_i = 1'b1;
		end else begin
			data_ar_addr_i  = addr;
			data_ar_valid_i = 1'b1;
		end
		n = 0;
		done = 1'b0;
		while (!done && n < TIMEOUT) begin
			@(negedge clock);
			done = fetch ? inst_ar_ready_o : data_ar_ready_o;
			@(posedge clock);
			#1;
			n++;
		end
		inst_ar_valid_i = fetch ? 1'b0 : inst_ar_valid_i;
		data_ar_valid_i = fetch ? data_ar_valid_i : 1'b0;
		if (!done) begin
			report_timeout(fetch ? "fetch address accept" : "data read address accept");
		end else begin
			// response expected from here on
			if (fetch)
				inst_busy = 1'b1;
			else
				load_busy = 1'b1;
			n = 0;
			done = 1'b0;
			while (!done && n < TIMEOUT) begin
				// random back-pressure
				rdy = ($urandom % 4) != 0;
				if (fetch)
					inst_r_ready_i = rdy;
				else
					data_r_ready_i = rdy;
				@(negedge clock);
				done = rdy & (fetch ? inst_r_valid_o : data_r_valid_o);
				rsp = fetch ? inst_r_o : data_r_o;
				@(posedge clock);
				#1;
				n++;
			end
			if (!done)
				report_timeout(fetch ? "fetch response" : "data read response");
		end
		if (fetch) begin
			inst_r_ready_i = 1'b0;
			inst_busy      = 1'b0;
		end else begin
			data_r_ready_i = 1'b0;
			load_busy      = 1'b0;
		end
	endtask

	task automatic write_data(input addr_t addr, input data_t data, input strb_t strb,
			output resp_t resp, output bit tx_seen, output logic [7:0] tx_byte);
		int n;
		bit done;
		bit rdy;
		bit first;
		resp = '0;
		tx_seen = 1'b0;
		tx_byte = '0;
		data_aw_addr_i  = addr;
		data_w_i        = '{data: data, strb: strb};
		data_aw_valid_i = 1'b1;
		data_w_valid_i  = 1'b1;
		n = 0;
		done = 1'b0;
		while (!done && n < TIMEOUT) begin
			@(negedge clock);
			done = data_aw_ready_o & data_w_ready_o;
			@(posedge clock);
			#1;
			n++;
		end
		data_aw_valid_i = 1'b0;
		data_w_valid_i  = 1'b0;
		if (!done) begin
			report_timeout("write address and data accept");
		end else begin
			store_busy = 1'b1;
			n = 0;
			done = 1'b0;
			first = 1'b1;
			while (!done && n < TIMEOUT) begin
				rdy = ($urandom % 4) != 0;
				data_b_ready_i = rdy;
				@(negedge clock);
				// uart strobe belongs to the first cycle of b valid
				if (data_b_valid_o && first) begin
					tx_seen = uart_tx_valid_o;
					tx_byte = uart_tx_o;
					first = 1'b0;
				end
				done = data_b_valid_o & rdy;
				resp = data_b_resp_o;
				@(posedge clock);
				#1;
				n++;
			end
			if (!done)
				report_timeout("write response");
		end
		data_b_ready_i = 1'b0;
		store_busy     = 1'b0;
	endtask

	task automatic read_expect(input bit fetch, input addr_t addr, input data_t exp_data,
			input resp_t exp_resp);
		r_chan_t rsp;
		read_port(fetch, addr, rsp);
		expect_equal(fetch ? "inst_r_o.data" : "data_r_o.data", rsp.data, exp_data);
		expect_equal(fetch ? "inst_r_o.resp" : "data_r_o.resp", 32'(rsp.resp), 32'(exp_resp));
	endtask

	task automatic write_expect(input addr_t addr, input data_t data, input strb_t strb,
			input resp_t exp_resp);
		resp_t      resp;
		bit         tx_seen;
		logic [7:0] tx_byte;
		write_data(addr, data, strb, resp, tx_seen, tx_byte);
		expect_equal("data_b_resp_o", 32'(resp), 32'(exp_resp));
		expect_equal("uart_tx_valid_o", 32'(tx_seen), 32'd0);
	endtask

	initial begin
		r_chan_t    rsp_a;
		r_chan_t    rsp_b;
		resp_t      bresp;
		bit         tx_seen;
		logic [7:0] tx_byte;
		data_t      wdata;
		data_t      t0;
		data_t      t1;
		strb_t      strb;
		addr_t      alias_addr;
		int         j;

		void'($urandom(32'hd1e04d98));
		errors = 0;
		checks = 0;
		inst_busy = 1'b0;
		load_busy = 1'b0;
		store_busy = 1'b0;
		clock = 1'b0;
		rst_i = 1'b1;
		inst_ar_addr_i = '0;
		inst_ar_valid_i = 1'b0;
		inst_r_ready_i = 1'b0;
		data_ar_addr_i = '0;
		data_ar_valid_i = 1'b0;
		data_r_ready_i = 1'b0;
		data_aw_addr_i = '0;
		data_aw_valid_i = 1'b0;
		data_w_i = '0;
		data_w_valid_i = 1'b0;
		data_b_ready_i = 1'b0;
		repeat (4) @(posedge clock);
		#1;
		rst_i = 1'b0;

		expect_equal("inst_r_valid_o", 32'(inst_r_valid_o), 32'd0);
		expect_equal("data_r_valid_o", 32'(data_r_valid_o), 32'd0);
		expect_equal("data_b_valid_o", 32'(data_b_valid_o), 32'd0);
		expect_equal("uart_tx_valid_o", 32'(uart_tx_valid_o), 32'd0);

		// distinct word indices spread over the whole SRAM
		for (int k = 0; k < NWORDS; k++)
			idx_list[k] = k * 61 + ($urandom % 61);

		// full-word fill followed by partial writes with random strobes
		for (int k = 0; k < NWORDS; k++) begin
			wdata = $urandom;
			write_expect(word_addr(k), wdata, 4'hf, RESP_OKAY);
			model[idx_list[k]] = wdata;
		end
		for (int k = 0; k < 2 * NWORDS; k++) begin
			j = $urandom % NWORDS;
			wdata = $urandom;
			strb = strb_t'($urandom);
			write_expect(word_addr(j), wdata, strb, RESP_OKAY);
			model[idx_list[j]] = merge_strobes(model[idx_list[j]], wdata, strb);
		end
		for (int k = 0; k < NWORDS; k++)
			read_expect(1'b0, word_addr(k), model[idx_list[k]], RESP_OKAY);
		for (int k = 0; k < NWORDS; k++)
			read_expect(1'b1, word_addr(k), model[idx_list[k]], RESP_OKAY);

		// fetch, load and store raised together
		for (int r = 0; r < 4; r++) begin
			wdata = $urandom;
			fork
				read_port(1'b1, word_addr(3 * r), rsp_a);
				read_port(1'b0, word_addr(3 * r + 1), rsp_b);
				write_data(word_addr(3 * r + 2), wdata, 4'hf, bresp, tx_seen, tx_byte);
			join
			model[idx_list[3 * r + 2]] = wdata;
			expect_equal("inst_r_o.data", rsp_a.data, model[idx_list[3 * r]]);
			expect_equal("data_r_o.data", rsp_b.data, model[idx_list[3 * r + 1]]);
			expect_equal("data_b_resp_o", 32'(bresp), 32'(RESP_OKAY));
			read_expect(1'b0, word_addr(3 * r + 2), wdata, RESP_OKAY);
		end

		// uart transmit
		for (int k = 0; k < 2; k++) begin
			wdata = $urandom;
			write_data(UART_ADDR, wdata, 4'h1, bresp, tx_seen, tx_byte);
			expect_equal("data_b_resp_o", 32'(bresp), 32'(RESP_OKAY));
			expect_equal("uart_tx_valid_o", 32'(tx_seen), 32'd1);
			expect_equal("uart_tx_o", 32'(tx_byte), 32'(wdata[7:0]));
		end

		// clint counter
		read_port(1'b0, CLINT_BASE, rsp_a);
		t0 = rsp_a.data;
		read_port(1'b0, CLINT_BASE, rsp_b);
		t1 = rsp_b.data;
		checks++;
		assert (t1 > t0) else begin
			errors++;
			$display("FAIL data_r_o.data: mtime low %h not above %h", t1, t0);
		end
		expect_equal("data_r_o.resp", 32'(rsp_b.resp), 32'(RESP_OKAY));
		read_expect(1'b0, CLINT_BASE + 32'd4, 32'h0, RESP_OKAY);

		// decode errors with one address aliasing a used SRAM word in its low bits
		alias_addr = UNMAPPED | (word_addr(0) & 32'h0000_0fff);
		read_expect(1'b0, alias_addr, 32'h0, RESP_DECERR);
		read_expect(1'b1, SRAM_BASE + SRAM_BYTES, 32'h0, RESP_DECERR);
		read_expect(1'b0, UART_ADDR, 32'h0, RESP_DECERR);
		write_expect(alias_addr, $urandom, 4'hf, RESP_DECERR);
		write_expect(CLINT_BASE, $urandom, 4'hf, RESP_DECERR);
		write_expect(SRAM_BASE + SRAM_BYTES, $urandom, 4'hf, RESP_DECERR);
		for (int k = 0; k < NWORDS; k++)
			read_expect(1'b0, word_addr(k), model[idx_list[k]], RESP_OKAY);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== filelist.f ====
verilog/soc_pkg.sv
verilog/axi_arbiter.sv
verilog/axi_xbar.sv
verilog/axi_sram.sv
verilog/axi_uart.sv
verilog/axi_clint.sv
verilog/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mem_subsys -f filelist.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
